/* alu_consts.svh */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Integer datapath width of the core
`define XLEN 64

// Shift amount field, enough for 0 to XLEN-1
`define SHAMT_W 6

`endif

/* alu_pkg.sv */
package alu_pkg;

	// ALU class handed over by the main decoder
	typedef enum logic [1:0] {
		ALU_CLASS_MEM    = 2'b00, // Address calc, always add
		ALU_CLASS_BRANCH = 2'b01, // Compare, always subtract
		ALU_CLASS_REG    = 2'b10, // funct3 and funct7 decide
		ALU_CLASS_IMM    = 2'b11  // funct3 decides
	} alu_class_e;

	// Bit 2 set means b is inverted and adder carry-in is one
	typedef enum logic [3:0] {
		ALU_AND  = 4'b0000,
		ALU_OR   = 4'b0001,
		ALU_ADD  = 4'b0010,
		ALU_SLT  = 4'b0111, // Uses adder in subtract mode
		ALU_SUB  = 4'b0110,
		ALU_SLTU = 4'b0101, // Uses adder in subtract mode
		ALU_XOR  = 4'b1000,
		ALU_SLL  = 4'b1001,
		ALU_SRL  = 4'b1010,
		ALU_SRA  = 4'b1011
	} alu_oper_e;

endpackage

/* alu_ctrl.sv */
`timescale 1ns/1ps

module alu_ctrl (
	input  alu_pkg::alu_class_e alu_op,
	input  logic [2:0]          funct3,
	input  logic [6:0]          funct7,
	input  logic                word,
	output alu_pkg::alu_oper_e  oper
);

	alu_pkg::alu_oper_e dec; // Operation before word restriction

	always_comb begin
		case (alu_op)
			alu_pkg::ALU_CLASS_MEM:    dec = alu_pkg::ALU_ADD;
			alu_pkg::ALU_CLASS_BRANCH: dec = alu_pkg::ALU_SUB;
			alu_pkg::ALU_CLASS_REG: begin
				case (funct3)
					3'b000:  dec = funct7[5] ? alu_pkg::ALU_SUB : alu_pkg::ALU_ADD;
					3'b001:  dec = alu_pkg::ALU_SLL;
					3'b010:  dec = alu_pkg::ALU_SLT;
					3'b011:  dec = alu_pkg::ALU_SLTU;
					3'b100:  dec = alu_pkg::ALU_XOR;
					3'b101:  dec = funct7[5] ? alu_pkg::ALU_SRA : alu_pkg::ALU_SRL;
					3'b110:  dec = alu_pkg::ALU_OR;
					default: dec = alu_pkg::ALU_AND;
				endcase
			end
			alu_pkg::ALU_CLASS_IMM: begin
				// No SUBI, so funct7 only matters for right shifts
				case (funct3)
					3'b000:  dec = alu_pkg::ALU_ADD;
					3'b001:  dec = alu_pkg::ALU_SLL;
					3'b010:  dec = alu_pkg::ALU_SLT;
					3'b011:  dec = alu_pkg::ALU_SLTU;
					3'b100:  dec = alu_pkg::ALU_XOR;
					3'b101:  dec = funct7[5] ? alu_pkg::ALU_SRA : alu_pkg::ALU_SRL;
					3'b110:  dec = alu_pkg::ALU_OR;
					default: dec = alu_pkg::ALU_AND;
				endcase
			end
			default: dec = alu_pkg::ALU_ADD; // Unknown class
		endcase

		if (word) begin
			case (dec)
				alu_pkg::ALU_ADD,
				alu_pkg::ALU_SUB,
				alu_pkg::ALU_SLL,
				alu_pkg::ALU_SRL,
				alu_pkg::ALU_SRA: oper = dec;
				default:          oper = alu_pkg::ALU_ADD; // No W form exists
			endcase
		end else begin
			oper = dec;
		end
	end

endmodule

/* alu_adder.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_adder (
	input  logic [`XLEN-1:0] in_a,
	input  logic [`XLEN-1:0] in_b,
	input  logic             cin,
	output logic [`XLEN-1:0] sum,
	output logic             cout,
	output logic             ovf,
	output logic             zero
);

	logic [`XLEN:0] full; // Sum with carry bit on top

	assign full = {1'b0, in_a} + {1'b0, in_b} + {{`XLEN{1'b0}}, cin};
	assign sum  = full[`XLEN-1:0];
	assign cout = full[`XLEN];

	// Same operand signs but a different result sign
	assign ovf = (in_a[`XLEN-1] == in_b[`XLEN-1]) && (sum[`XLEN-1] != in_a[`XLEN-1]);

	assign zero = ~(|sum);

endmodule

/* alu_shifter.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_shifter (
	input  logic [`XLEN-1:0]    din,
	input  logic [`SHAMT_W-1:0] shamt,
	input  logic                left,
	input  logic                arith,
	output logic [`XLEN-1:0]    dout
);

	logic [2*`XLEN-1:0] win_r; // Fill bits above the operand
	logic [2*`XLEN-1:0] win_l; // Zeros below the operand
	logic [`SHAMT_W:0]  lidx;  // XLEN minus shamt

	assign win_r = {{`XLEN{arith & din[`XLEN-1]}}, din};
	assign win_l = {din, {`XLEN{1'b0}}};

	// Window start for left shift, 64 down to 1
	assign lidx = {1'b1, {`SHAMT_W{1'b0}}} - {1'b0, shamt};

	always_comb begin
		if (left) begin
			dout = win_l[lidx +: `XLEN];
		end else begin
			dout = win_r[shamt +: `XLEN]; // Logical or arithmetic by fill
		end
	end

endmodule

/* alu.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu (
	input  alu_pkg::alu_oper_e oper,
	input  logic               word,
	input  logic [`XLEN-1:0]   alu_a,
	input  logic [`XLEN-1:0]   alu_b,
	output logic [`XLEN-1:0]   alu_out,
	output logic               alu_zero,
	output logic               alu_carry,
	output logic               alu_overflow
);

	localparam int HALF = `XLEN / 2;

	logic [`XLEN-1:0]    b_s;      // b after optional invert
	logic [`XLEN-1:0]    sum;
	logic [`XLEN-1:0]    sft_in;
	logic [`XLEN-1:0]    sft_out;
	logic [`SHAMT_W-1:0] shamt;
	logic                slt;
	logic                sltu;
	logic [`XLEN-1:0]    raw;      // Result before word extension

	assign b_s = alu_b ^ {`XLEN{oper[2]}};

	alu_adder adder_inst (
		.in_a (alu_a),
		.in_b (b_s),
		.cin  (oper[2]),
		.sum  (sum),
		.cout (alu_carry),
		.ovf  (alu_overflow),
		.zero (alu_zero)
	);

	// Word shifts see only the low half of a
	always_comb begin
		if (!word) begin
			sft_in = alu_a;
		end else if (oper == alu_pkg::ALU_SRA) begin
			sft_in = {{HALF{alu_a[HALF-1]}}, alu_a[HALF-1:0]};
		end else begin
			sft_in = {{HALF{1'b0}}, alu_a[HALF-1:0]};
		end
	end

	assign shamt = word ? {1'b0, alu_b[`SHAMT_W-2:0]} : alu_b[`SHAMT_W-1:0];

	alu_shifter shifter_inst (
		.din   (sft_in),
		.shamt (shamt),
		.left  (oper == alu_pkg::ALU_SLL),
		.arith (oper == alu_pkg::ALU_SRA),
		.dout  (sft_out)
	);

	// Adder computes a - b for both compares
	assign slt  = sum[`XLEN-1] ^ alu_overflow;
	assign sltu = ~alu_carry; // Borrow out

	always_comb begin
		case (oper)
			alu_pkg::ALU_AND:  raw = alu_a & alu_b;
			alu_pkg::ALU_OR:   raw = alu_a | alu_b;
			alu_pkg::ALU_XOR:  raw = alu_a ^ alu_b;
			alu_pkg::ALU_SLT:  raw = {{(`XLEN-1){1'b0}}, slt};
			alu_pkg::ALU_SLTU: raw = {{(`XLEN-1){1'b0}}, sltu};
			alu_pkg::ALU_SLL,
			alu_pkg::ALU_SRL,
			alu_pkg::ALU_SRA:  raw = sft_out;
			default:           raw = sum; // ADD and SUB
		endcase
	end

	assign alu_out = word ? {{HALF{raw[HALF-1]}}, raw[HALF-1:0]} : raw;

endmodule

/* exec_stage.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module exec_stage (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  alu_pkg::alu_class_e alu_op,
	input  logic [2:0]          funct3,
	input  logic [6:0]          funct7,
	input  logic                word,
	input  logic [`XLEN-1:0]    src_a,
	input  logic [`XLEN-1:0]    src_b,
	output logic                out_valid,
	output logic [`XLEN-1:0]    result,
	output logic                zero,
	output logic                carry,
	output logic                overflow
);

	alu_pkg::alu_oper_e oper;
	logic [`XLEN-1:0]   alu_res;
	logic               alu_zero;
	logic               alu_carry;
	logic               alu_overflow;

	alu_ctrl alu_ctrl_inst (
		.alu_op (alu_op),
		.funct3 (funct3),
		.funct7 (funct7),
		.word   (word),
		.oper   (oper)
	);

	alu alu_inst (
		.oper         (oper),
		.word         (word),
		.alu_a        (src_a),
		.alu_b        (src_b),
		.alu_out      (alu_res),
		.alu_zero     (alu_zero),
		.alu_carry    (alu_carry),
		.alu_overflow (alu_overflow)
	);

	// Single output stage, no stall
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			result    <= '0;
			zero      <= 1'b0;
			carry     <= 1'b0;
			overflow  <= 1'b0;
		end else begin
			out_valid <= in_valid;
			result    <= alu_res;
			zero      <= alu_zero;
			carry     <= alu_carry;
			overflow  <= alu_overflow;
		end
	end

endmodule

/* exec_stage_assert.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module exec_assert (
	input logic             clk,
	input logic             rst,
	input logic             in_valid,
	input logic             word,
	input logic             out_valid,
	input logic [`XLEN-1:0] result
);

	a_rst_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// One result per accepted input, exactly one cycle later
	a_valid_follows: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> out_valid == $past(in_valid))
		else $error("out_valid does not follow in_valid of the previous cycle");

	a_word_sext: assert property (@(posedge clk) disable iff (rst)
		(in_valid && word) |=> result[`XLEN-1:`XLEN/2] == {(`XLEN/2){result[`XLEN/2-1]}})
		else $error("word result is not sign-extended from bit 31");

endmodule

/* exec_stage_tb.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module exec_stage_tb;

	localparam int HALF         = `XLEN / 2;
	localparam int RESET_CYCLES = 3;
	localparam int N_DIRECTED   = 64;  // Upper bound on directed and gap cycles
	localparam int N_REG        = 80;
	localparam int N_MIXED      = 300;
	localparam int MAX_CYCLES   = RESET_CYCLES + N_DIRECTED + 3 * (N_REG + N_MIXED) + 50;
	localparam logic [63:0] LATENCY = 64'd6;  // Issue edge to sampling negedge, in ns

	localparam alu_pkg::alu_class_e CL_MEM = alu_pkg::ALU_CLASS_MEM;
	localparam alu_pkg::alu_class_e CL_BR  = alu_pkg::ALU_CLASS_BRANCH;
	localparam alu_pkg::alu_class_e CL_REG = alu_pkg::ALU_CLASS_REG;
	localparam alu_pkg::alu_class_e CL_IMM = alu_pkg::ALU_CLASS_IMM;
	localparam logic [6:0] F7_ALT = 7'b0100000;  // SUB and SRA select
	localparam logic [`XLEN-1:0] MAX_POS = {1'b0, {(`XLEN-1){1'b1}}};
	localparam logic [`XLEN-1:0] MIN_NEG = {1'b1, {(`XLEN-1){1'b0}}};
	localparam logic [`XLEN-1:0] ONES    = {`XLEN{1'b1}};
	localparam logic [`XLEN-1:0] NEG_PAT = 64'hf0f0_1234_5678_9abd;
	localparam logic [5:0] SHIFT_AMTS [5] = '{6'd0, 6'd1, 6'd31, 6'd32, 6'd63};

	typedef struct packed {
		logic [`XLEN-1:0] res;
		logic             zero;
		logic             carry;
		logic             ovf;
	} expect_t;

	logic                clk = 1'b0;
	logic                rst;
	logic                in_valid;
	alu_pkg::alu_class_e alu_op;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic                word;
	logic [`XLEN-1:0]    src_a;
	logic [`XLEN-1:0]    src_b;
	logic                out_valid;
	logic [`XLEN-1:0]    result;
	logic                zero;
	logic                carry;
	logic                overflow;

	logic [31:0] lfsr_state;
	expect_t     exp_q[$];
	time         issue_q[$];  // Issue time of each queued expectation
	int          checks = 0;
	int          mismatches = 0;
	int          other_errors = 0;
	int          cycles = 0;

	exec_stage exec_stage_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.alu_op    (alu_op),
		.funct3    (funct3),
		.funct7    (funct7),
		.word      (word),
		.src_a     (src_a),
		.src_b     (src_b),
		.out_valid (out_valid),
		.result    (result),
		.zero      (zero),
		.carry     (carry),
		.overflow  (overflow)
	);

	bind exec_stage exec_assert exec_assert_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.word      (word),
		.out_valid (out_valid),
		.result    (result)
	);

	always #2 clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
	endtask

	// Expected result and flags from the RV64 integer rules
	function automatic expect_t ref_model(input alu_pkg::alu_class_e cls, input logic [2:0] f3,
		input logic [6:0] f7, input logic w, input logic [`XLEN-1:0] a,
		input logic [`XLEN-1:0] b);
		expect_t                 e;
		alu_pkg::alu_oper_e      op;
		logic                    sub;
		logic [`XLEN:0]          full;
		logic signed [`XLEN-1:0] sa;
		logic signed [HALF-1:0]  sa32;
		logic [HALF-1:0]         r32;
		case (f3)
			3'b000:  op = (cls == CL_REG && f7[5]) ? alu_pkg::ALU_SUB : alu_pkg::ALU_ADD;
			3'b001:  op = alu_pkg::ALU_SLL;
			3'b010:  op = alu_pkg::ALU_SLT;
			3'b011:  op = alu_pkg::ALU_SLTU;
			3'b100:  op = alu_pkg::ALU_XOR;
			3'b101:  op = f7[5] ? alu_pkg::ALU_SRA : alu_pkg::ALU_SRL;
			3'b110:  op = alu_pkg::ALU_OR;
			default: op = alu_pkg::ALU_AND;
		endcase
		if (cls == CL_MEM)
			op = alu_pkg::ALU_ADD;
		if (cls == CL_BR)
			op = alu_pkg::ALU_SUB;
		if (w && !(op inside {alu_pkg::ALU_ADD, alu_pkg::ALU_SUB, alu_pkg::ALU_SLL,
			alu_pkg::ALU_SRL, alu_pkg::ALU_SRA}))
			op = alu_pkg::ALU_ADD;  // No word form
		sub = (op == alu_pkg::ALU_SUB) || (op == alu_pkg::ALU_SLT) || (op == alu_pkg::ALU_SLTU);
		full = sub ? {1'b0, a} - {1'b0, b} : {1'b0, a} + {1'b0, b};
		e.carry = sub ? !full[`XLEN] : full[`XLEN];  // No borrow counts as carry
		e.zero = (full[`XLEN-1:0] == '0);
		if (sub)
			e.ovf = (a[`XLEN-1] != b[`XLEN-1]) && (full[`XLEN-1] != a[`XLEN-1]);
		else
			e.ovf = (a[`XLEN-1] == b[`XLEN-1]) && (full[`XLEN-1] != a[`XLEN-1]);
		sa = a;
		sa32 = a[HALF-1:0];
		e.res = '0;
		if (w) begin
			case (op)
				alu_pkg::ALU_SLL: r32 = a[HALF-1:0] << b[4:0];
				alu_pkg::ALU_SRL: r32 = a[HALF-1:0] >> b[4:0];
				alu_pkg::ALU_SRA: r32 = sa32 >>> b[4:0];
				alu_pkg::ALU_SUB: r32 = a[HALF-1:0] - b[HALF-1:0];
				default:          r32 = a[HALF-1:0] + b[HALF-1:0];
			endcase
			e.res = {{HALF{r32[HALF-1]}}, r32};
		end else begin
			case (op)
				alu_pkg::ALU_AND:  e.res = a & b;
				alu_pkg::ALU_OR:   e.res = a | b;
				alu_pkg::ALU_XOR:  e.res = a ^ b;
				alu_pkg::ALU_SUB:  e.res = a - b;
				alu_pkg::ALU_SLT:  e.res[0] = $signed(a) < $signed(b);
				alu_pkg::ALU_SLTU: e.res[0] = a < b;
				alu_pkg::ALU_SLL:  e.res = a << b[5:0];
				alu_pkg::ALU_SRL:  e.res = a >> b[5:0];
				alu_pkg::ALU_SRA:  e.res = sa >>> b[5:0];
				default:           e.res = a + b;
			endcase
		end
		return e;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic issue(input alu_pkg::alu_class_e cls, input logic [2:0] f3,
		input logic [6:0] f7, input logic w, input logic [`XLEN-1:0] a,
		input logic [`XLEN-1:0] b);
		@(posedge clk);
		in_valid <= 1'b1;
		alu_op   <= cls;
		funct3   <= f3;
		funct7   <= f7;
		word     <= w;
		src_a    <= a;
		src_b    <= b;
		exp_q.push_back(ref_model(cls, f3, f7, w, a, b));
		issue_q.push_back($time);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic random_op(input logic reg_only);
		logic [63:0]         r;
		alu_pkg::alu_class_e cls;
		logic [2:0]          f3;
		logic [6:0]          f7;
		logic                w;
		logic [`XLEN-1:0]    a;
		logic [`XLEN-1:0]    b;
		take_bits(2, r);
		cls = reg_only ? CL_REG : alu_pkg::alu_class_e'(r[1:0]);
		take_bits(3, r);
		f3 = r[2:0];
		take_bits(7, r);
		f7 = r[6:0];
		take_bits(2, r);
		w = !reg_only && (r[1:0] == 2'b00);
		take_bits(`XLEN, a);
		take_bits(`XLEN, b);
		take_bits(3, r);
		if (r[2:0] == 3'b000)
			b = a;  // Equal operands now and then
		issue(cls, f3, f7, w, a, b);
		take_bits(2, r);
		if (r[1:0] == 2'b00) begin
			take_bits(1, r);
			idle(1 + int'(r[0]));
		end
	endtask

	task automatic directed_ops();
		logic [`XLEN-1:0] b;
		issue(CL_MEM, 3'b111, F7_ALT, 1'b0, 64'h1234, 64'h10);  // Funct fields ignored
		issue(CL_MEM, 3'b010, 7'h7f, 1'b0, MAX_POS, 64'd1);
		issue(CL_MEM, 3'b101, 7'h00, 1'b0, -64'd8, 64'd8);
		issue(CL_BR, 3'b000, 7'h00, 1'b0, 64'hdead_beef, 64'hdead_beef);
		issue(CL_BR, 3'b110, F7_ALT, 1'b0, MIN_NEG, MIN_NEG);
		issue(CL_BR, 3'b001, 7'h00, 1'b0, 64'd5, 64'd9);
		idle(2);
		issue(CL_REG, 3'b000, 7'h00, 1'b0, MAX_POS, 64'd1);  // Signed overflow
		issue(CL_REG, 3'b000, 7'h00, 1'b0, ONES, 64'd1);     // Carry out
		issue(CL_REG, 3'b000, 7'h00, 1'b0, MIN_NEG, MIN_NEG);
		issue(CL_REG, 3'b000, F7_ALT, 1'b0, 64'd0, 64'd1);   // Borrow
		issue(CL_REG, 3'b000, F7_ALT, 1'b0, MIN_NEG, 64'd1);
		issue(CL_REG, 3'b000, F7_ALT, 1'b0, MAX_POS, ONES);
		issue(CL_REG, 3'b010, 7'h00, 1'b0, ONES, 64'd1);
		issue(CL_REG, 3'b011, 7'h00, 1'b0, ONES, 64'd1);
		issue(CL_REG, 3'b010, 7'h00, 1'b0, 64'd1, MIN_NEG);
		issue(CL_REG, 3'b011, 7'h00, 1'b0, 64'd1, MIN_NEG);
		idle(2);
		for (int i = 0; i < 5; i++) begin
			b = 64'hffff_ff00_0000_0000 | {{(`XLEN-6){1'b0}}, SHIFT_AMTS[i]};
			issue(CL_REG, 3'b001, 7'h00, 1'b0, NEG_PAT, b);
			issue(CL_REG, 3'b101, 7'h00, 1'b0, NEG_PAT, b);
			issue(CL_REG, 3'b101, F7_ALT, 1'b0, NEG_PAT, b);
		end
		issue(CL_IMM, 3'b101, F7_ALT, 1'b0, 64'h7654_3210_fedc_ba98, 64'd63);
		issue(CL_IMM, 3'b101, 7'h00, 1'b0, NEG_PAT, 64'd4);
		idle(2);
		issue(CL_REG, 3'b000, 7'h00, 1'b1, 64'h7fff_ffff, 64'd1);  // ADDW wraps
		issue(CL_REG, 3'b000, F7_ALT, 1'b1, 64'd0, 64'd1);
		issue(CL_IMM, 3'b000, 7'h00, 1'b1, 64'h1234_5678_0000_0010, 64'hffff_0000_0000_0001);
		issue(CL_REG, 3'b001, 7'h00, 1'b1, 64'h3, 64'd31);
		issue(CL_REG, 3'b001, 7'h00, 1'b1, 64'h3, 64'd33);  // Amount masks to 1
		issue(CL_REG, 3'b101, 7'h00, 1'b1, 64'hffff_0000_8000_0000, 64'd4);
		issue(CL_REG, 3'b101, F7_ALT, 1'b1, 64'h0000_ffff_8000_0000, 64'd4);
		issue(CL_IMM, 3'b101, F7_ALT, 1'b1, 64'h8000_0000, 64'd63);
		issue(CL_IMM, 3'b101, 7'h00, 1'b1, 64'h9000_0000, 64'd0);
		issue(CL_REG, 3'b010, 7'h00, 1'b1, ONES, 64'd1);  // No SLTW, falls back to add
		idle(2);
	endtask

	initial begin
		rst        = 1'b1;
		in_valid   = 1'b0;
		alu_op     = CL_MEM;
		funct3     = '0;
		funct7     = '0;
		word       = 1'b0;
		src_a      = '0;
		src_b      = '0;
		lfsr_state = 32'h1d93b92d;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		directed_ops();
		repeat (N_REG) random_op(1'b1);
		repeat (N_MIXED) random_op(1'b0);
		idle(1);
		while (issue_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin : compare
		expect_t e;
		time     t_issue;
		if (rst) begin
			check_value("out_valid", 64'd0, 64'(out_valid));
		end else if (out_valid) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("error at %0t: out_valid high with no operation pending", $time);
			end else begin
				e = exp_q.pop_front();
				t_issue = issue_q.pop_front();
				check_value("latency", LATENCY, 64'($time - t_issue));
				check_value("result", e.res, result);
				check_value("zero", 64'(e.zero), 64'(zero));
				check_value("carry", 64'(e.carry), 64'(carry));
				check_value("overflow", 64'(e.ovf), 64'(overflow));
			end
		end else if (issue_q.size() != 0 && 64'($time - issue_q[0]) > LATENCY) begin
			other_errors++;
			$display("error at %0t: no result for the operation issued at %0t",
				$time, issue_q[0]);
			void'(exp_q.pop_front());
			void'(issue_q.pop_front());
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("error: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule

/* compile.f */
+incdir+.
alu_pkg.sv
alu_ctrl.sv
alu_adder.sv
alu_shifter.sv
alu.sv
exec_stage.sv
exec_stage_assert.sv
exec_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module exec_stage_tb -o exec_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/exec_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -F -q "*** TEST PASSED ***" sim.log; then
	echo "Run result: pass"
	exit 0
else
	echo "Run result: fail"
	exit 1
fi
